// File: design/router_regs_apb_decode.sv
/* APB access capture and address decode */
`timescale 1ns/1ps

module router_regs_apb_decode (
    input  logic                        core_clk_ifc,
    input  logic                        peripheral_sresetn_core,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  router_regs_pkg::paddr_t     paddr,
    input  router_regs_pkg::data_t      pwdata,
    input  router_regs_pkg::strb_t      pstrb,
    output logic                        pready,
    output router_regs_pkg::reg_req_t   req
);

    localparam int word_w = $bits(router_regs_pkg::paddr_t) - 2;

    router_regs_pkg::apb_phase_t state;
    logic                        access_start;
    logic [word_w-1:0]           word_addr;

    // Captured transfer fields
    logic                        write_q;
    logic                        bad_q;
    router_regs_pkg::reg_idx_t   idx_q;
    router_regs_pkg::data_t      wdata_q;
    router_regs_pkg::strb_t      strb_q;

    // Accesses are whole words so the byte offset is dropped
    assign word_addr    = paddr[$bits(router_regs_pkg::paddr_t)-1:2];
    assign access_start = (state == router_regs_pkg::idle) && psel && penable;

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            state <= router_regs_pkg::idle;
        end else begin
            case (state)
                router_regs_pkg::idle: begin
                    if (access_start) begin
                        state <= router_regs_pkg::wait_done;
                    end
                end
                // Back to idle after the single wait cycle
                default: state <= router_regs_pkg::idle;
            endcase
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (access_start) begin
            write_q <= pwrite;
            bad_q   <= (word_addr >= router_regs_pkg::total_regs);
            idx_q   <= router_regs_pkg::reg_idx_t'(word_addr);
            wdata_q <= pwdata;
            strb_q  <= pstrb;
        end
    end

    assign pready = (state == router_regs_pkg::wait_done);

    always_comb begin
        req.valid    = pready;
        req.write    = write_q;
        req.bad_addr = bad_q;
        req.idx      = idx_q;
        req.wdata    = wdata_q;
        req.strb     = strb_q;
    end

endmodule

// File: design/router_regs_control.sv
/* Control registers and sample request */
`timescale 1ns/1ps

module router_regs_control (
    input  logic                        core_clk_ifc,
    input  logic                        peripheral_sresetn_core,
    input  router_regs_pkg::reg_req_t   req,
    output router_regs_pkg::data_t      port_enable_con,
    output router_regs_pkg::data_t      port_enable_stat,
    output router_regs_pkg::data_t      counter_con,
    output router_regs_pkg::port_mask_t sample_pulse
);

    logic                        wr_ok;
    logic                        wr_enable_con;
    logic                        wr_counter_con;
    router_regs_pkg::port_mask_t sample_req;
    router_regs_pkg::port_mask_t sample_req_d;

    // Merge write data into a register under the byte strobes
    function automatic router_regs_pkg::data_t lane_merge(
        input router_regs_pkg::data_t cur,
        input router_regs_pkg::data_t wdata,
        input router_regs_pkg::strb_t strb
    );
        router_regs_pkg::data_t res;
        res = cur;
        for (int b = 0; b < $bits(router_regs_pkg::strb_t); b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

    // Bad addresses can alias onto low indices, so they are excluded here
    assign wr_ok          = req.valid && req.write && !req.bad_addr;
    assign wr_enable_con  = wr_ok && (req.idx == router_regs_pkg::addr_port_enable_con);
    assign wr_counter_con = wr_ok && (req.idx == router_regs_pkg::addr_counter_con);

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            port_enable_con  <= router_regs_pkg::port_enable_rst;
            port_enable_stat <= router_regs_pkg::port_enable_rst;
            counter_con      <= '0;
        end else begin
            if (wr_enable_con) begin
                port_enable_con <= lane_merge(port_enable_con, req.wdata, req.strb);
            end
            if (wr_counter_con) begin
                counter_con <= lane_merge(counter_con, req.wdata, req.strb);
            end
            // Status reports the applied enables one cycle behind
            port_enable_stat <= router_regs_pkg::data_t'(
                router_regs_pkg::port_mask_t'(port_enable_con));
        end
    end

    ////////////////////
    // Sample request edge detect

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            sample_req   <= '0;
            sample_req_d <= '0;
        end else begin
            sample_req   <= router_regs_pkg::port_mask_t'(counter_con);
            sample_req_d <= sample_req;
        end
    end

    assign sample_pulse = sample_req & ~sample_req_d;

endmodule

// File: design/router_regs_counters.sv
/* Drop counters and snapshot words */
`timescale 1ns/1ps

module router_regs_counters (
    input  logic                         core_clk_ifc,
    input  logic                         peripheral_sresetn_core,
    input  router_regs_pkg::port_mask_t  sample_pulse,
    input  router_regs_pkg::port_mask_t  buf_full_drop,
    input  router_regs_pkg::port_stats_t port_stats [router_regs_pkg::num_ports],
    input  router_regs_pkg::reg_req_t    req,
    output router_regs_pkg::data_t       snap_rdata
);

    localparam int sel_w = $clog2(router_regs_pkg::snap_words);
    localparam int cpp   = router_regs_pkg::cnts_per_port;

    router_regs_pkg::port_mask_t drop_d;
    router_regs_pkg::port_mask_t drop_rise;
    router_regs_pkg::cnt_t       drop_cnt [router_regs_pkg::num_ports];
    router_regs_pkg::cnt_t       snap_q   [router_regs_pkg::snap_words];
    logic                        in_snap;
    router_regs_pkg::reg_idx_t   snap_off;

    // A held drop line counts only once
    assign drop_rise = buf_full_drop & ~drop_d;

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            drop_d <= '0;
            for (int p = 0; p < router_regs_pkg::num_ports; p++) begin
                drop_cnt[p] <= '0;
            end
        end else begin
            drop_d <= buf_full_drop;
            for (int p = 0; p < router_regs_pkg::num_ports; p++) begin
                if (sample_pulse[p]) begin
                    // A coincident event opens the new interval
                    drop_cnt[p] <= drop_rise[p] ? router_regs_pkg::cnt_t'(1) : '0;
                end else if (drop_rise[p]) begin
                    drop_cnt[p] <= drop_cnt[p] + 1'b1;
                end
            end
        end
    end

    ////////////////////
    // Snapshot capture

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            for (int i = 0; i < router_regs_pkg::snap_words; i++) begin
                snap_q[i] <= '0;
            end
        end else begin
            for (int p = 0; p < router_regs_pkg::num_ports; p++) begin
                if (sample_pulse[p]) begin
                    snap_q[p*cpp + router_regs_pkg::cnt_pkt]  <= port_stats[p].pkt_cnt;
                    snap_q[p*cpp + router_regs_pkg::cnt_byte] <= port_stats[p].byte_cnt;
                    snap_q[p*cpp + router_regs_pkg::cnt_err]  <= port_stats[p].err_cnt;
                    snap_q[p*cpp + router_regs_pkg::cnt_drop] <= drop_cnt[p];
                end
            end
        end
    end

    // Read select within the snapshot area
    assign in_snap  = (req.idx >= router_regs_pkg::addr_counters_start) &&
                      (req.idx < router_regs_pkg::total_regs);
    assign snap_off = req.idx -
                      router_regs_pkg::reg_idx_t'(router_regs_pkg::addr_counters_start);

    assign snap_rdata = in_snap ? router_regs_pkg::data_t'(snap_q[snap_off[sel_w-1:0]]) : '0;

endmodule

// File: design/router_regs_pkg.sv
/* Router register block definitions */
package router_regs_pkg;

    ////////////////////
    // Dimensions

    localparam int num_ports     = 4;
    localparam int cnts_per_port = 4;
    localparam int snap_words    = num_ports * cnts_per_port;

    // Word order inside one port's snapshot group
    localparam int cnt_pkt  = 0;
    localparam int cnt_byte = 1;
    localparam int cnt_err  = 2;
    localparam int cnt_drop = 3;

    ////////////////////
    // Register map in word addresses

    localparam int addr_version_id       = 0;
    localparam int addr_num_regs         = 1;
    localparam int addr_ports_param      = 2;
    localparam int addr_mtu_param        = 3;
    localparam int addr_port_enable_con  = 4;
    localparam int addr_port_enable_stat = 5;
    localparam int addr_counter_con      = 6;
    localparam int addr_counters_start   = 7;
    localparam int total_regs            = addr_counters_start + snap_words;

    ////////////////////
    // Types

    typedef logic [31:0]          data_t;
    typedef logic [31:0]          cnt_t;
    typedef logic [3:0]           strb_t;
    typedef logic [14:0]          paddr_t;
    typedef logic [4:0]           reg_idx_t;
    typedef logic [num_ports-1:0] port_mask_t;

    // Live datapath counts of one port
    typedef struct packed {
        cnt_t pkt_cnt;
        cnt_t byte_cnt;
        cnt_t err_cnt;
    } port_stats_t;

    // One APB access as seen by the register logic
    typedef struct packed {
        logic     valid;
        logic     write;
        logic     bad_addr;
        reg_idx_t idx;
        data_t    wdata;
        strb_t    strb;
    } reg_req_t;

    typedef enum logic {
        idle,
        wait_done
    } apb_phase_t;

    // Constant and reset values
    localparam data_t version_id_val  = 32'h0100_000A;
    localparam int    mtu_bytes       = 5000;
    localparam data_t port_enable_rst = data_t'(port_mask_t'('1));

endpackage

// File: design/router_regs_readback.sv
/* Read data mux and error response */
`timescale 1ns/1ps

module router_regs_readback (
    input  router_regs_pkg::reg_req_t req,
    input  router_regs_pkg::data_t    port_enable_con,
    input  router_regs_pkg::data_t    port_enable_stat,
    input  router_regs_pkg::data_t    counter_con,
    input  router_regs_pkg::data_t    snap_rdata,
    output router_regs_pkg::data_t    prdata,
    output logic                      pslverr
);

    router_regs_pkg::data_t reg_val;

    // Register value at the requested index
    always_comb begin
        case (req.idx)
            router_regs_pkg::addr_version_id: begin
                reg_val = router_regs_pkg::version_id_val;
            end
            router_regs_pkg::addr_num_regs: begin
                reg_val = router_regs_pkg::data_t'(router_regs_pkg::total_regs);
            end
            router_regs_pkg::addr_ports_param: begin
                reg_val = router_regs_pkg::data_t'(router_regs_pkg::num_ports);
            end
            router_regs_pkg::addr_mtu_param: begin
                reg_val = router_regs_pkg::data_t'(router_regs_pkg::mtu_bytes);
            end
            router_regs_pkg::addr_port_enable_con:  reg_val = port_enable_con;
            router_regs_pkg::addr_port_enable_stat: reg_val = port_enable_stat;
            router_regs_pkg::addr_counter_con:      reg_val = counter_con;
            // Everything above is the snapshot area
            default:                                reg_val = snap_rdata;
        endcase
    end

    ////////////////////
    // Response

    // Data only during the response cycle of a good access
    always_comb begin
        if (req.valid && !req.bad_addr) begin
            prdata = reg_val;
        end else begin
            prdata = '0;
        end
    end

    assign pslverr = req.valid && req.bad_addr;

endmodule

// File: design/router_regs_top.sv
/* Router register block top */
`timescale 1ns/1ps

module router_regs_top (
    input  logic                         core_clk_ifc,
    input  logic                         peripheral_sresetn_core,
    // APB slave
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  router_regs_pkg::paddr_t      paddr,
    input  router_regs_pkg::data_t       pwdata,
    input  router_regs_pkg::strb_t       pstrb,
    output router_regs_pkg::data_t       prdata,
    output logic                         pready,
    output logic                         pslverr,
    // Ingress ports
    input  router_regs_pkg::port_mask_t  buf_full_drop,
    input  router_regs_pkg::port_stats_t port_stats [router_regs_pkg::num_ports],
    output router_regs_pkg::port_mask_t  port_enable
);

    router_regs_pkg::reg_req_t   req;
    router_regs_pkg::data_t      port_enable_con;
    router_regs_pkg::data_t      port_enable_stat;
    router_regs_pkg::data_t      counter_con;
    router_regs_pkg::data_t      snap_rdata;
    router_regs_pkg::port_mask_t sample_pulse;

    router_regs_apb_decode i_apb_decode (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .psel                    ( psel                    ),
        .penable                 ( penable                 ),
        .pwrite                  ( pwrite                  ),
        .paddr                   ( paddr                   ),
        .pwdata                  ( pwdata                  ),
        .pstrb                   ( pstrb                   ),
        .pready                  ( pready                  ),
        .req                     ( req                     )
    );

    router_regs_control i_control (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .req                     ( req                     ),
        .port_enable_con         ( port_enable_con         ),
        .port_enable_stat        ( port_enable_stat        ),
        .counter_con             ( counter_con             ),
        .sample_pulse            ( sample_pulse            )
    );

    router_regs_counters i_counters (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .sample_pulse            ( sample_pulse            ),
        .buf_full_drop           ( buf_full_drop           ),
        .port_stats              ( port_stats              ),
        .req                     ( req                     ),
        .snap_rdata              ( snap_rdata              )
    );

    router_regs_readback i_readback (
        .req                     ( req                     ),
        .port_enable_con         ( port_enable_con         ),
        .port_enable_stat        ( port_enable_stat        ),
        .counter_con             ( counter_con             ),
        .snap_rdata              ( snap_rdata              ),
        .prdata                  ( prdata                  ),
        .pslverr                 ( pslverr                 )
    );

    // Enables follow the control register directly
    assign port_enable = router_regs_pkg::port_mask_t'(port_enable_con);

endmodule

// File: filelist.f
design/router_regs_pkg.sv
design/router_regs_apb_decode.sv
design/router_regs_control.sv
design/router_regs_counters.sv
design/router_regs_readback.sv
design/router_regs_top.sv
sim/router_regs_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the router register testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module router_regs_tb -f filelist.f
./obj_dir/Vrouter_regs_tb | tee sim.log

if grep -q "All checks passed" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// File: sim/router_regs_tb.sv
/* Router register block testbench */
`timescale 1ns/1ps

module router_regs_tb;

    logic                         core_clk_ifc = 1'b0;
    logic                         peripheral_sresetn_core;
    logic                         psel;
    logic                         penable;
    logic                         pwrite;
    router_regs_pkg::paddr_t      paddr;
    router_regs_pkg::data_t       pwdata;
    router_regs_pkg::strb_t       pstrb;
    router_regs_pkg::data_t       prdata;
    logic                         pready;
    logic                         pslverr;
    router_regs_pkg::port_mask_t  buf_full_drop;
    router_regs_pkg::port_stats_t port_stats [router_regs_pkg::num_ports];
    router_regs_pkg::port_mask_t  port_enable;

    int seed        = 32'h2de9_2a51;
    int cycle_cnt   = 0;
    // Tests take well under 2000 cycles
    int cycle_limit = 4000;
    int err_count   = 0;
    int check_count = 0;
    int test_errs   = 0;
    int top_word    = (1 << ($bits(router_regs_pkg::paddr_t) - 2)) - 1;

    // Shadow state of the register block
    router_regs_pkg::data_t en_sh;
    router_regs_pkg::data_t cc_sh;
    router_regs_pkg::data_t snap_sh [router_regs_pkg::num_ports][router_regs_pkg::cnts_per_port];
    int                     drop_sh [router_regs_pkg::num_ports];

    // Expected response of each transfer in flight
    router_regs_pkg::data_t exp_data_q [$];
    logic                   exp_err_q  [$];
    logic                   exp_rd_q   [$];
    int                     exp_word_q [$];
    router_regs_pkg::data_t e_data;
    logic                   e_err;
    logic                   e_rd;
    int                     e_word;

    router_regs_top i_router_regs_top (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .psel                    ( psel                    ),
        .penable                 ( penable                 ),
        .pwrite                  ( pwrite                  ),
        .paddr                   ( paddr                   ),
        .pwdata                  ( pwdata                  ),
        .pstrb                   ( pstrb                   ),
        .prdata                  ( prdata                  ),
        .pready                  ( pready                  ),
        .pslverr                 ( pslverr                 ),
        .buf_full_drop           ( buf_full_drop           ),
        .port_stats              ( port_stats              ),
        .port_enable             ( port_enable             )
    );

    always #50 core_clk_ifc = ~core_clk_ifc;

    always @(posedge core_clk_ifc) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    ////////////////////
    // Reference model

    function automatic router_regs_pkg::data_t port_bits();
        return (router_regs_pkg::data_t'(1) << router_regs_pkg::num_ports) -
               router_regs_pkg::data_t'(1);
    endfunction

    function automatic router_regs_pkg::data_t lane_write(
        input router_regs_pkg::data_t old,
        input router_regs_pkg::data_t wdata,
        input router_regs_pkg::strb_t strb
    );
        router_regs_pkg::data_t keep;
        keep = '0;
        for (int b = 0; b < 4; b++) begin
            keep[8*b +: 8] = {8{strb[b]}};
        end
        return (old & ~keep) | (wdata & keep);
    endfunction

    function automatic router_regs_pkg::data_t expected_reg(input int word);
        router_regs_pkg::data_t val;
        int                     off;
        val = '0;
        off = word - router_regs_pkg::addr_counters_start;
        case (word)
            router_regs_pkg::addr_version_id:       val = 32'h0100_000A;
            router_regs_pkg::addr_num_regs:         val = 32'd23;
            router_regs_pkg::addr_ports_param:      val = 32'd4;
            router_regs_pkg::addr_mtu_param:        val = 32'd5000;
            router_regs_pkg::addr_port_enable_con:  val = en_sh;
            router_regs_pkg::addr_port_enable_stat: val = en_sh & port_bits();
            router_regs_pkg::addr_counter_con:      val = cc_sh;
            default: begin
                if (off >= 0 && word < router_regs_pkg::total_regs) begin
                    val = snap_sh[off / router_regs_pkg::cnts_per_port]
                                 [off % router_regs_pkg::cnts_per_port];
                end
            end
        endcase
        return val;
    endfunction

    task automatic take_snapshot(input int p);
        snap_sh[p][router_regs_pkg::cnt_pkt]  = port_stats[p].pkt_cnt;
        snap_sh[p][router_regs_pkg::cnt_byte] = port_stats[p].byte_cnt;
        snap_sh[p][router_regs_pkg::cnt_err]  = port_stats[p].err_cnt;
        snap_sh[p][router_regs_pkg::cnt_drop] = router_regs_pkg::data_t'(drop_sh[p]);
        drop_sh[p] = 0;
    endtask

    task automatic record_write(
        input int                     word,
        input router_regs_pkg::data_t wdata,
        input router_regs_pkg::strb_t strb
    );
        router_regs_pkg::data_t      merged;
        router_regs_pkg::port_mask_t rise;
        if (word == router_regs_pkg::addr_port_enable_con) begin
            en_sh = lane_write(en_sh, wdata, strb);
        end else if (word == router_regs_pkg::addr_counter_con) begin
            merged = lane_write(cc_sh, wdata, strb);
            // Only a 0 to 1 change of a port bit samples that port
            rise = router_regs_pkg::port_mask_t'(merged) & ~router_regs_pkg::port_mask_t'(cc_sh);
            for (int p = 0; p < router_regs_pkg::num_ports; p++) begin
                if (rise[p]) begin
                    take_snapshot(p);
                end
            end
            cc_sh = merged;
        end
    endtask

    ////////////////////
    // APB master

    task automatic apb_transfer(
        input int                     word,
        input logic                   wr,
        input router_regs_pkg::data_t wdata,
        input router_regs_pkg::strb_t strb
    );
        int waits;
        @(posedge core_clk_ifc);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = router_regs_pkg::paddr_t'(word * 4);
        pwdata  = wdata;
        pstrb   = strb;
        @(posedge core_clk_ifc);
        #1;
        penable = 1'b1;
        // Ready is sampled mid cycle
        waits = 0;
        @(negedge core_clk_ifc);
        while (!pready) begin
            waits++;
            @(negedge core_clk_ifc);
        end
        // Fixed latency of one wait state
        check_count++;
        if (waits != 1) begin
            $display("ERROR t=%0t pready wait states (word %0d): got %0d expected %0d",
                     $time, word, waits, 1);
            err_count++;
        end
        @(posedge core_clk_ifc);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        if (pready !== 1'b0) begin
            $display("ERROR t=%0t pready after completion: got %b expected 0", $time, pready);
            err_count++;
        end
    endtask

    task automatic apb_write(
        input int                     word,
        input router_regs_pkg::data_t wdata,
        input router_regs_pkg::strb_t strb
    );
        exp_data_q.push_back('0);
        exp_err_q.push_back(word >= router_regs_pkg::total_regs);
        exp_rd_q.push_back(1'b0);
        exp_word_q.push_back(word);
        apb_transfer(word, 1'b1, wdata, strb);
        record_write(word, wdata, strb);
    endtask

    task automatic apb_read(input int word);
        exp_data_q.push_back(expected_reg(word));
        exp_err_q.push_back(word >= router_regs_pkg::total_regs);
        exp_rd_q.push_back(1'b1);
        exp_word_q.push_back(word);
        apb_transfer(word, 1'b0, '0, '0);
    endtask

    // Compare each completed transfer against its expectation
    always @(negedge core_clk_ifc) begin
        if (psel && penable && pready) begin
            if (exp_err_q.size() == 0) begin
                $display("ERROR t=%0t a transfer completed with nothing expected", $time);
                err_count++;
            end else begin
                e_data = exp_data_q.pop_front();
                e_err  = exp_err_q.pop_front();
                e_rd   = exp_rd_q.pop_front();
                e_word = exp_word_q.pop_front();
                check_count++;
                if (pslverr !== e_err) begin
                    $display("ERROR t=%0t pslverr (word %0d): got %b expected %b",
                             $time, e_word, pslverr, e_err);
                    err_count++;
                end
                if (e_rd && prdata !== e_data) begin
                    $display("ERROR t=%0t prdata (word %0d): got %h expected %h",
                             $time, e_word, prdata, e_data);
                    err_count++;
                end
            end
        end
    end

    ////////////////////
    // Test helpers

    task automatic check_enable_out();
        check_count++;
        if (port_enable !== router_regs_pkg::port_mask_t'(en_sh)) begin
            $display("ERROR t=%0t port_enable: got %h expected %h",
                     $time, port_enable, router_regs_pkg::port_mask_t'(en_sh));
            err_count++;
        end
    endtask

    task automatic end_test(input string name);
        $display("Test %s finished with %0d errors", name, err_count - test_errs);
        test_errs = err_count;
    endtask

    task automatic read_snapshots();
        for (int w = router_regs_pkg::addr_counters_start; w < router_regs_pkg::total_regs; w++) begin
            apb_read(w);
        end
    endtask

    task automatic randomize_stats();
        for (int p = 0; p < router_regs_pkg::num_ports; p++) begin
            port_stats[p].pkt_cnt  = $random(seed);
            port_stats[p].byte_cnt = $random(seed);
            port_stats[p].err_cnt  = $random(seed);
        end
    endtask

    task automatic drop_pulse(input int p, input int len);
        @(posedge core_clk_ifc);
        #1;
        buf_full_drop[p] = 1'b1;
        repeat (len) @(posedge core_clk_ifc);
        #1;
        buf_full_drop[p] = 1'b0;
        @(posedge core_clk_ifc);
        drop_sh[p]++;
    endtask

    ////////////////////
    // Test sequence

    initial begin
        int                          word;
        router_regs_pkg::data_t      wdata;
        router_regs_pkg::strb_t      strb;
        router_regs_pkg::port_mask_t mask;

        peripheral_sresetn_core = 1'b0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        pstrb         = '0;
        buf_full_drop = '0;
        en_sh         = port_bits();
        cc_sh         = '0;
        for (int p = 0; p < router_regs_pkg::num_ports; p++) begin
            port_stats[p] = '0;
            drop_sh[p]    = 0;
            for (int c = 0; c < router_regs_pkg::cnts_per_port; c++) begin
                snap_sh[p][c] = '0;
            end
        end
        repeat (8) @(posedge core_clk_ifc);
        #1;
        peripheral_sresetn_core = 1'b1;

        // Reset and constant values, then the first invalid and the top address
        check_enable_out();
        for (int w = 0; w < router_regs_pkg::total_regs; w++) begin
            apb_read(w);
        end
        apb_read(router_regs_pkg::total_regs);
        apb_read(top_word);
        end_test("reset_values");

        for (int i = 0; i < 30; i++) begin
            word  = ($random(seed) & 1) ? router_regs_pkg::addr_port_enable_con
                                        : router_regs_pkg::addr_counter_con;
            wdata = $random(seed);
            strb  = router_regs_pkg::strb_t'($random(seed));
            apb_write(word, wdata, strb);
            check_enable_out();
            apb_read(word);
            apb_read(router_regs_pkg::addr_port_enable_stat);
        end
        apb_write(router_regs_pkg::addr_version_id, $random(seed), 4'hF);
        apb_write(router_regs_pkg::addr_port_enable_stat, $random(seed), 4'hF);
        apb_write(router_regs_pkg::addr_counters_start + 1, $random(seed), 4'hF);
        // Word 36 aliases onto the enable register in the low index bits
        apb_write(32 + router_regs_pkg::addr_port_enable_con, $random(seed), 4'hF);
        check_enable_out();
        for (int w = 0; w < router_regs_pkg::total_regs; w++) begin
            apb_read(w);
        end
        end_test("control_writes");

        for (int r = 0; r < 2; r++) begin
            randomize_stats();
            apb_write(router_regs_pkg::addr_counter_con, '0, 4'hF);
            mask = router_regs_pkg::port_mask_t'($random(seed));
            apb_write(router_regs_pkg::addr_counter_con, router_regs_pkg::data_t'(mask), 4'hF);
            read_snapshots();
        end
        end_test("snapshots");

        apb_write(router_regs_pkg::addr_counter_con, '0, 4'hF);
        for (int p = 0; p < router_regs_pkg::num_ports; p++) begin
            for (int k = 0; k <= p; k++) begin
                drop_pulse(p, 1);
            end
        end
        drop_pulse(2, 6);
        repeat (2) @(posedge core_clk_ifc);
        apb_write(router_regs_pkg::addr_counter_con, port_bits(), 4'hF);
        read_snapshots();
        // No events in this interval
        apb_write(router_regs_pkg::addr_counter_con, '0, 4'hF);
        apb_write(router_regs_pkg::addr_counter_con, port_bits(), 4'hF);
        read_snapshots();
        end_test("drop_counts");

        for (int i = 0; i < 200; i++) begin
            if ($random(seed) & 1) begin
                word = $random(seed) & 31;
            end else begin
                word = $random(seed) & top_word;
            end
            apb_read(word);
        end
        end_test("random_reads");

        repeat (2) @(posedge core_clk_ifc);
        if (exp_err_q.size() != 0) begin
            $display("Some transfers never completed");
            err_count++;
        end
        $display("Checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
